/* Makefile */
# Verilator build and run for the sequence controller testbench

VERILATOR ?= verilator
TOP       ?= tb_seq_ctrl
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST)) logic/seq_ctrl_macros.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "^TEST RESULT: PASS$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/seq_ctrl_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "seq_ctrl_macros.svh"

module seq_ctrl_checker (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic [`SEQ_DATA_W-1:0]   ir,
    input  wire cpu_isa_pkg::alu_flags_t  alu_flags,
    input  wire seq_ctrl_pkg::ctrl_word_t ctrl,
    input  wire logic [`SEQ_REG_W-1:0]    src1,
    input  wire logic [`SEQ_REG_W-1:0]    src2,
    input  wire logic [`SEQ_REG_W-1:0]    dest,
    input  wire logic                     ready,
    input  wire logic                     halt,
    output int                            err_count,
    output int                            decode_count
);

    seq_ctrl_pkg::seq_state_e m_state = seq_ctrl_pkg::ST_RESET;   // Model state
    seq_ctrl_pkg::ctrl_word_t exp_ctrl;
    logic                     exp_ready;
    int                       errors   = 0;
    int                       decodes  = 0;

    assign err_count    = errors;
    assign decode_count = decodes;

    // --------------------------------------------------
    // Reference sequence
    // --------------------------------------------------
    function automatic seq_ctrl_pkg::seq_state_e model_next(
        input seq_ctrl_pkg::seq_state_e st,
        input logic [`SEQ_DATA_W-1:0]   w
    );
        logic [`SEQ_OPC_W-1:0] op;
        op = w[15:11];
        case (st)
            seq_ctrl_pkg::ST_RESET:      return seq_ctrl_pkg::ST_READY;
            seq_ctrl_pkg::ST_READY:      return seq_ctrl_pkg::ST_FETCH_ADDR;
            seq_ctrl_pkg::ST_FETCH_ADDR: return seq_ctrl_pkg::ST_FETCH_IR;
            seq_ctrl_pkg::ST_FETCH_IR:   return seq_ctrl_pkg::ST_DECODE;
            seq_ctrl_pkg::ST_DECODE: begin
                if (op == cpu_isa_pkg::OP_HLT)
                    return seq_ctrl_pkg::ST_HALT;
                if (op == cpu_isa_pkg::OP_LD || op == cpu_isa_pkg::OP_OTM)
                    return seq_ctrl_pkg::ST_EXECUTE;
                if (op >= cpu_isa_pkg::OP_ADD && op <= cpu_isa_pkg::OP_SHR && !w[10])
                    return seq_ctrl_pkg::ST_ALU_WB;     // Result kept
                return seq_ctrl_pkg::ST_FETCH_ADDR;
            end
            seq_ctrl_pkg::ST_HALT:       return seq_ctrl_pkg::ST_HALT;
            default:                     return seq_ctrl_pkg::ST_FETCH_ADDR;
        endcase
    endfunction

    // Expected control word per state and instruction
    function automatic seq_ctrl_pkg::ctrl_word_t model_ctrl(
        input seq_ctrl_pkg::seq_state_e st,
        input logic [`SEQ_DATA_W-1:0]   w,
        input cpu_isa_pkg::alu_flags_t  f
    );
        seq_ctrl_pkg::ctrl_word_t c;
        logic [`SEQ_OPC_W-1:0]    op;
        logic                     hit;
        c        = '0;                       // Selects at their first value
        c.alu_op = cpu_isa_pkg::ALU_NONE;
        op       = w[15:11];
        hit      = 1'b0;
        if (st == seq_ctrl_pkg::ST_RESET) c.pc_rst = 1'b1;
        if (st == seq_ctrl_pkg::ST_FETCH_ADDR) c.mem_en = 1'b1;
        if (st == seq_ctrl_pkg::ST_FETCH_IR) begin
            c.ir_ld  = 1'b1;
            c.pc_inc = 1'b1;
        end
        if (st == seq_ctrl_pkg::ST_ALU_WB) begin
            c.reg_we   = 1'b1;
            c.data_src = seq_ctrl_pkg::DATA_ALU;
        end
        if (st == seq_ctrl_pkg::ST_EXECUTE) begin
            c.reg_we   = (op == cpu_isa_pkg::OP_LD);
            c.data_src = (op == cpu_isa_pkg::OP_LD) ? seq_ctrl_pkg::DATA_MEM
                                                    : seq_ctrl_pkg::DATA_IMM;
            c.mem_en   = (op == cpu_isa_pkg::OP_OTM);  // OTM keeps reading
            c.addr_src = (op == cpu_isa_pkg::OP_OTM) ? seq_ctrl_pkg::ADDR_IMM_L
                                                     : seq_ctrl_pkg::ADDR_PC;
            c.out_ld   = (op == cpu_isa_pkg::OP_OTM);
        end
        if (st == seq_ctrl_pkg::ST_DECODE) begin
            if (op >= cpu_isa_pkg::OP_BDQ && op <= cpu_isa_pkg::OP_BXS) begin
                // Low two opcode bits pick the flag rule
                case (op[1:0])
                    2'd0:    hit = f.z;
                    2'd1:    hit = ~f.z;
                    2'd2:    hit = f.n ^ f.v;
                    default: hit = f.c;
                endcase
                c.pc_ld      = hit;
                c.flg_rst    = hit;
                c.bra_direct = hit && (op <= cpu_isa_pkg::OP_BDS);
            end else if (op >= cpu_isa_pkg::OP_ADD && op <= cpu_isa_pkg::OP_SHR) begin
                c.alu_op = cpu_isa_pkg::alu_op_e'(4'(op - 5'd20));  // Same order as ADD..SHR
                c.flg_ld = 1'b1;
                c.alu_ld = !w[10];
            end else begin
                c.pc_ld    = op inside {cpu_isa_pkg::OP_JMP, cpu_isa_pkg::OP_JPL,
                                        cpu_isa_pkg::OP_RET};
                c.stk_ld   = (op == cpu_isa_pkg::OP_JPL);
                c.out_ld   = (op == cpu_isa_pkg::OP_OTR);
                c.mem_en   = op inside {cpu_isa_pkg::OP_LD, cpu_isa_pkg::OP_OTM,
                                        cpu_isa_pkg::OP_ST, cpu_isa_pkg::OP_STX};
                c.mem_wr   = op inside {cpu_isa_pkg::OP_ST, cpu_isa_pkg::OP_STX};
                c.reg_we   = op inside {cpu_isa_pkg::OP_LDI, cpu_isa_pkg::OP_MOV};
                if (op == cpu_isa_pkg::OP_JMP || op == cpu_isa_pkg::OP_JPL)
                    c.pc_src = seq_ctrl_pkg::PC_SRC1;
                if (op == cpu_isa_pkg::OP_RET) c.pc_src = seq_ctrl_pkg::PC_RETURN;
                if (op == cpu_isa_pkg::OP_OTR) c.out_sel = seq_ctrl_pkg::OUT_REG;
                if (op == cpu_isa_pkg::OP_MOV) c.data_src = seq_ctrl_pkg::DATA_SRC1;
                if (op == cpu_isa_pkg::OP_LD || op == cpu_isa_pkg::OP_OTM)
                    c.addr_src = seq_ctrl_pkg::ADDR_IMM_L;
                if (op == cpu_isa_pkg::OP_ST) c.addr_src = seq_ctrl_pkg::ADDR_IMM_H;
                if (op == cpu_isa_pkg::OP_STX) c.addr_src = seq_ctrl_pkg::ADDR_SRC2;
            end
        end
        return c;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    // --------------------------------------------------
    // Model step and per-cycle compare
    // --------------------------------------------------
    always @(posedge clk) begin
        if (!rst_n) m_state <= seq_ctrl_pkg::ST_RESET;
        else        m_state <= model_next(m_state, ir);
    end

    always @(negedge clk) begin     // Mid-cycle with all outputs settled
        exp_ctrl  = model_ctrl(m_state, ir, alu_flags);
        exp_ready = !(m_state == seq_ctrl_pkg::ST_RESET || m_state == seq_ctrl_pkg::ST_HALT ||
                      (m_state == seq_ctrl_pkg::ST_DECODE && ir[15:11] == cpu_isa_pkg::OP_HLT));
        compare_value("ctrl", 32'(ctrl), 32'(exp_ctrl));
        compare_value("src1", 32'(src1), 32'(ir[2:0]));
        compare_value("src2", 32'(src2), 32'(ir[6:4]));
        compare_value("dest", 32'(dest), 32'(ir[10:8]));
        compare_value("ready", 32'(ready), 32'(exp_ready));
        compare_value("halt", 32'(halt), 32'(m_state == seq_ctrl_pkg::ST_HALT));
        if (m_state == seq_ctrl_pkg::ST_DECODE) decodes++;
    end

endmodule

`default_nettype wire

/* dv/seq_ctrl_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module seq_ctrl_properties (
    input wire logic                     clk,
    input wire logic                     rst_n,
    input wire seq_ctrl_pkg::seq_state_e state,
    input wire seq_ctrl_pkg::ctrl_word_t ctrl
);

    // --------------------------------------------------
    // Sequencer state
    // --------------------------------------------------
    state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state inside {[seq_ctrl_pkg::ST_RESET : seq_ctrl_pkg::ST_HALT]})
        else $error("Sequencer state outside the legal encodings");

    // Only a reset edge leaves halt
    halt_sticky: assert property (@(posedge clk)
        (state == seq_ctrl_pkg::ST_HALT && rst_n) |=> (state == seq_ctrl_pkg::ST_HALT))
        else $error("Sequencer left halt without a reset");

    // --------------------------------------------------
    // Control word exclusivity
    // --------------------------------------------------
    write_needs_enable: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.mem_wr |-> ctrl.mem_en)
        else $error("Memory write issued without memory enable");

    // Register write and ALU result load never share a cycle
    no_we_with_alu_ld: assert property (@(posedge clk) disable iff (!rst_n)
        !(ctrl.reg_we && ctrl.alu_ld))
        else $error("Register write and ALU load high in the same cycle");

endmodule

bind seq_ctrl_top seq_ctrl_properties u_props (
    .clk   (clk),
    .rst_n (rst_n),
    .state (state),
    .ctrl  (ctrl)
);

`default_nettype wire

/* dv/tb_seq_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "seq_ctrl_macros.svh"

module tb_seq_ctrl;

    localparam int N_INSTR        = 400;
    localparam int TIMEOUT_CYCLES = N_INSTR * 4 + 200;  // Slowest class plus reset slack
    localparam int HALT_WAIT      = 3;

    logic                     clk;
    logic                     rst_n;
    logic [`SEQ_DATA_W-1:0]   ir;
    cpu_isa_pkg::alu_flags_t  alu_flags;
    seq_ctrl_pkg::ctrl_word_t ctrl;
    logic [`SEQ_REG_W-1:0]    src1;
    logic [`SEQ_REG_W-1:0]    src2;
    logic [`SEQ_REG_W-1:0]    dest;
    logic                     ready;
    logic                     halt;

    integer seed;
    int     n_instr;            // Words presented after an ir_ld
    int     halt_cycles;
    int     tb_errors;
    int     cycle_count = 0;
    int     chk_errors;
    int     decode_count;

    seq_ctrl_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .ir        (ir),
        .alu_flags (alu_flags),
        .ctrl      (ctrl),
        .src1      (src1),
        .src2      (src2),
        .dest      (dest),
        .ready     (ready),
        .halt      (halt)
    );

    seq_ctrl_checker chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .ir           (ir),
        .alu_flags    (alu_flags),
        .ctrl         (ctrl),
        .src1         (src1),
        .src2         (src2),
        .dest         (dest),
        .ready        (ready),
        .halt         (halt),
        .err_count    (chk_errors),
        .decode_count (decode_count)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;      // 100 ns period

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------
    task automatic drive_random_instr();
        logic [31:0] r;
        r = $random(seed);
        if (r[15:11] == cpu_isa_pkg::OP_HLT && r[21:20] != 2'b00)
            r[15:11] = cpu_isa_pkg::OP_NOP;     // Keep halts rare
        ir = r[15:0];
    endtask

    task automatic drive_random_flags();
        logic [31:0] r;
        r = $random(seed);
        alu_flags = r[3:0];
    endtask

    // Sample mid-cycle and react just after the next rising edge
    task automatic step_cycle();
        logic ld_ir;
        logic ld_flags;
        logic halted;
        @(negedge clk);
        ld_ir    = ctrl.ir_ld;
        ld_flags = ctrl.flg_ld | ctrl.flg_rst;
        halted   = halt;
        @(posedge clk);
        #1;
        if (!rst_n) rst_n = 1'b1;       // One-cycle restart pulse
        if (ld_ir) begin
            drive_random_instr();
            n_instr++;
        end
        if (ld_flags) drive_random_flags();
        if (halted) halt_cycles++;
        else        halt_cycles = 0;
        if (halt_cycles == HALT_WAIT) rst_n = 1'b0;
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        logic at_fetch;
        seed        = 32'h7ac5;
        rst_n       = 1'b0;
        n_instr     = 0;
        halt_cycles = 0;
        tb_errors   = 0;
        drive_random_instr();
        drive_random_flags();
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        while (n_instr < N_INSTR) step_cycle();
        // Let the last instruction finish
        do begin
            @(negedge clk);
            at_fetch = ctrl.mem_en && !ctrl.mem_wr && ctrl.addr_src == seq_ctrl_pkg::ADDR_PC;
        end while (!at_fetch && !halt);
        if (decode_count != n_instr) begin
            tb_errors++;
            $display("Instruction count off: %0d IR loads, %0d decodes",
                     n_instr, decode_count);
        end
        $display("Errors: %0d checker, %0d testbench", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* logic/cpu_isa_pkg.sv */
`default_nettype none

`include "seq_ctrl_macros.svh"

package cpu_isa_pkg;

    // --------------------------------------------------
    // Opcodes, IR[15:11]
    // --------------------------------------------------
    typedef enum logic [`SEQ_OPC_W-1:0] {
        OP_NOP = 5'd0,  // Codes 28..31 also act as NOP
        OP_HLT,
        OP_JMP,         // PC <= src1
        OP_JPL,         // Jump and link
        OP_RET,         // Return from JPL
        OP_OTR,         // Output <= register
        OP_OTM,         // Output <= memory, extra cycle
        OP_LDI,         // Load immediate low byte
        OP_LD,          // Load direct, extra cycle
        OP_ST,          // Store direct
        OP_STX,         // Store indexed
        OP_MOV,
        OP_BDQ,         // Direct branches
        OP_BDE,
        OP_BDT,
        OP_BDS,
        OP_BXQ,         // Indexed branches
        OP_BXE,
        OP_BXT,
        OP_BXS,
        OP_ADD,         // ALU group
        OP_SUB,         // CMP when IR[10] set
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOT,
        OP_SHL,
        OP_SHR
    } opcode_e;

    // ALU operation codes, same order as the ALU opcodes
    typedef enum logic [`SEQ_ALUOP_W-1:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOT  = 4'd5,
        ALU_SHL  = 4'd6,
        ALU_SHR  = 4'd7,
        ALU_NONE = 4'd9     // Idle, no operation requested
    } alu_op_e;

    // ALU status flags, v in the MSB
    typedef struct packed {
        logic v;    // Overflow
        logic n;    // Negative
        logic c;    // Carry
        logic z;    // Zero
    } alu_flags_t;

    // --------------------------------------------------
    // Decoded instruction
    // --------------------------------------------------
    typedef struct packed {
        opcode_e                opcode;
        alu_op_e                alu_op;         // ALU_NONE outside the ALU group
        logic                   is_alu;
        logic                   ignore_dest;    // IR[10], flags only
        logic                   take_branch;    // Condition met on a branch
        logic                   branch_direct;  // BDx vs BXx
        logic [`SEQ_REG_W-1:0]  src1;
        logic [`SEQ_REG_W-1:0]  src2;
        logic [`SEQ_REG_W-1:0]  dest;
    } decoded_t;

endpackage

`default_nettype wire

/* logic/ctrl_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl_encoder (
    input  wire seq_ctrl_pkg::seq_state_e state,
    input  wire cpu_isa_pkg::decoded_t    decoded,
    output seq_ctrl_pkg::ctrl_word_t      ctrl,
    output logic                          ready,
    output logic                          halt
);

    // All controls off, selects at their first value
    localparam seq_ctrl_pkg::ctrl_word_t CTRL_IDLE = '{
        pc_rst:     1'b0,
        pc_inc:     1'b0,
        pc_ld:      1'b0,
        pc_src:     seq_ctrl_pkg::PC_BRANCH,
        bra_direct: 1'b0,
        stk_ld:     1'b0,
        ir_ld:      1'b0,
        mem_en:     1'b0,
        mem_wr:     1'b0,
        addr_src:   seq_ctrl_pkg::ADDR_PC,
        reg_we:     1'b0,
        data_src:   seq_ctrl_pkg::DATA_IMM,
        alu_ld:     1'b0,
        alu_op:     cpu_isa_pkg::ALU_NONE,
        flg_ld:     1'b0,
        flg_rst:    1'b0,
        out_ld:     1'b0,
        out_sel:    seq_ctrl_pkg::OUT_MEM
    };

    always_comb begin
        ctrl  = CTRL_IDLE;
        ready = 1'b1;
        halt  = 1'b0;
        case (state)
            seq_ctrl_pkg::ST_RESET: begin
                ctrl.pc_rst = 1'b1;
                ready       = 1'b0;
            end
            seq_ctrl_pkg::ST_FETCH_ADDR: ctrl.mem_en = 1'b1;    // Read at PC
            seq_ctrl_pkg::ST_FETCH_IR: begin
                ctrl.ir_ld  = 1'b1;
                ctrl.pc_inc = 1'b1;     // Bump PC on the same edge
            end

            // --------------------------------------------------
            // Decode, single-cycle work happens here
            // --------------------------------------------------
            seq_ctrl_pkg::ST_DECODE: begin
                case (decoded.opcode)
                    cpu_isa_pkg::OP_HLT: ready = 1'b0;
                    cpu_isa_pkg::OP_JMP: begin
                        ctrl.pc_ld  = 1'b1;
                        ctrl.pc_src = seq_ctrl_pkg::PC_SRC1;
                    end
                    cpu_isa_pkg::OP_JPL: begin
                        ctrl.pc_ld  = 1'b1;
                        ctrl.pc_src = seq_ctrl_pkg::PC_SRC1;
                        ctrl.stk_ld = 1'b1;     // Save return address
                    end
                    cpu_isa_pkg::OP_RET: begin
                        ctrl.pc_ld  = 1'b1;
                        ctrl.pc_src = seq_ctrl_pkg::PC_RETURN;
                    end
                    cpu_isa_pkg::OP_OTR: begin
                        ctrl.out_ld  = 1'b1;
                        ctrl.out_sel = seq_ctrl_pkg::OUT_REG;
                    end
                    cpu_isa_pkg::OP_OTM, cpu_isa_pkg::OP_LD: begin
                        ctrl.mem_en   = 1'b1;   // Data lands in execute
                        ctrl.addr_src = seq_ctrl_pkg::ADDR_IMM_L;
                    end
                    cpu_isa_pkg::OP_LDI: begin
                        ctrl.reg_we   = 1'b1;
                        ctrl.data_src = seq_ctrl_pkg::DATA_IMM;
                    end
                    cpu_isa_pkg::OP_ST: begin
                        ctrl.mem_en   = 1'b1;
                        ctrl.mem_wr   = 1'b1;
                        ctrl.addr_src = seq_ctrl_pkg::ADDR_IMM_H;
                    end
                    cpu_isa_pkg::OP_STX: begin
                        ctrl.mem_en   = 1'b1;
                        ctrl.mem_wr   = 1'b1;
                        ctrl.addr_src = seq_ctrl_pkg::ADDR_SRC2;   // Address in src2
                    end
                    cpu_isa_pkg::OP_MOV: begin
                        ctrl.reg_we   = 1'b1;
                        ctrl.data_src = seq_ctrl_pkg::DATA_SRC1;
                    end
                    default: ;      // NOP, branches and ALU handled below
                endcase

                if (decoded.take_branch) begin
                    ctrl.pc_ld      = 1'b1;
                    ctrl.pc_src     = seq_ctrl_pkg::PC_BRANCH;
                    ctrl.bra_direct = decoded.branch_direct;
                    ctrl.flg_rst    = 1'b1;     // Condition consumed
                end

                if (decoded.is_alu) begin
                    ctrl.alu_op = decoded.alu_op;
                    ctrl.flg_ld = 1'b1;                     // Flags always kept
                    ctrl.alu_ld = !decoded.ignore_dest;     // CMP skips the result
                end
            end

            // --------------------------------------------------
            // Second cycle of LD and OTM
            // --------------------------------------------------
            seq_ctrl_pkg::ST_EXECUTE: begin
                if (decoded.opcode == cpu_isa_pkg::OP_LD) begin
                    ctrl.reg_we   = 1'b1;
                    ctrl.data_src = seq_ctrl_pkg::DATA_MEM;
                end else if (decoded.opcode == cpu_isa_pkg::OP_OTM) begin
                    ctrl.mem_en   = 1'b1;   // Hold the read while output loads
                    ctrl.addr_src = seq_ctrl_pkg::ADDR_IMM_L;
                    ctrl.out_ld   = 1'b1;
                    ctrl.out_sel  = seq_ctrl_pkg::OUT_MEM;
                end
            end
            seq_ctrl_pkg::ST_ALU_WB: begin
                ctrl.reg_we   = 1'b1;
                ctrl.data_src = seq_ctrl_pkg::DATA_ALU;
            end
            seq_ctrl_pkg::ST_HALT: begin
                halt  = 1'b1;
                ready = 1'b0;
            end
            default: ;      // ST_READY, nothing driven
        endcase
    end

endmodule

`default_nettype wire

/* logic/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "seq_ctrl_macros.svh"

module instr_decoder (
    input  wire logic [`SEQ_DATA_W-1:0] ir,
    input  wire cpu_isa_pkg::alu_flags_t alu_flags,
    output cpu_isa_pkg::decoded_t        decoded
);

    // IR field positions
    localparam int SRC1_LSB = 0;
    localparam int SRC2_LSB = 4;
    localparam int DEST_LSB = 8;
    localparam int IGN_BIT  = 10;     // Shares a bit with dest

    cpu_isa_pkg::opcode_e opcode;
    logic                 branch_cond;   // Flag rule for the branch kind
    logic                 is_branch;

    assign opcode = cpu_isa_pkg::opcode_e'(ir[`SEQ_DATA_W-1 -: `SEQ_OPC_W]);

    // --------------------------------------------------
    // Branch condition against the flags
    // --------------------------------------------------
    always_comb begin
        branch_cond = 1'b0;
        is_branch   = 1'b1;
        case (opcode)
            cpu_isa_pkg::OP_BDQ, cpu_isa_pkg::OP_BXQ: branch_cond = alu_flags.z;
            cpu_isa_pkg::OP_BDE, cpu_isa_pkg::OP_BXE: branch_cond = ~alu_flags.z;
            cpu_isa_pkg::OP_BDT, cpu_isa_pkg::OP_BXT: branch_cond = alu_flags.n ^ alu_flags.v;
            cpu_isa_pkg::OP_BDS, cpu_isa_pkg::OP_BXS: branch_cond = alu_flags.c;
            default:                                  is_branch   = 1'b0;
        endcase
    end

    // --------------------------------------------------
    // ALU op mapping and field split
    // --------------------------------------------------
    always_comb begin
        decoded        = '0;
        decoded.opcode = opcode;
        decoded.is_alu = 1'b1;          // Cleared below for the rest
        case (opcode)
            cpu_isa_pkg::OP_ADD: decoded.alu_op = cpu_isa_pkg::ALU_ADD;
            cpu_isa_pkg::OP_SUB: decoded.alu_op = cpu_isa_pkg::ALU_SUB;
            cpu_isa_pkg::OP_AND: decoded.alu_op = cpu_isa_pkg::ALU_AND;
            cpu_isa_pkg::OP_OR:  decoded.alu_op = cpu_isa_pkg::ALU_OR;
            cpu_isa_pkg::OP_XOR: decoded.alu_op = cpu_isa_pkg::ALU_XOR;
            cpu_isa_pkg::OP_NOT: decoded.alu_op = cpu_isa_pkg::ALU_NOT;
            cpu_isa_pkg::OP_SHL: decoded.alu_op = cpu_isa_pkg::ALU_SHL;
            cpu_isa_pkg::OP_SHR: decoded.alu_op = cpu_isa_pkg::ALU_SHR;
            default: begin
                decoded.alu_op = cpu_isa_pkg::ALU_NONE;
                decoded.is_alu = 1'b0;
            end
        endcase
        decoded.ignore_dest   = ir[IGN_BIT];
        decoded.take_branch   = is_branch & branch_cond;
        decoded.branch_direct = opcode inside {cpu_isa_pkg::OP_BDQ, cpu_isa_pkg::OP_BDE,
                                               cpu_isa_pkg::OP_BDT, cpu_isa_pkg::OP_BDS};
        decoded.src1          = ir[SRC1_LSB +: `SEQ_REG_W];
        decoded.src2          = ir[SRC2_LSB +: `SEQ_REG_W];
        decoded.dest          = ir[DEST_LSB +: `SEQ_REG_W];
    end

endmodule

`default_nettype wire

/* logic/seq_ctrl_macros.svh */
`ifndef SEQ_CTRL_MACROS_SVH
`define SEQ_CTRL_MACROS_SVH

// --------------------------------------------------
// Datapath widths
// --------------------------------------------------

// Instruction word, also the CPU data word
`define SEQ_DATA_W 16

// Opcode field, top bits of the instruction word
`define SEQ_OPC_W 5

// Register file index, eight registers
`define SEQ_REG_W 3

// ALU operation code
`define SEQ_ALUOP_W 4

// --------------------------------------------------
// Controller widths
// --------------------------------------------------

// Sequencer state encoding, room left for growth
`define SEQ_STATE_W 4

`endif

/* logic/seq_ctrl_pkg.sv */
`default_nettype none

`include "seq_ctrl_macros.svh"

package seq_ctrl_pkg;

    // --------------------------------------------------
    // Sequencer states
    // --------------------------------------------------
    typedef enum logic [`SEQ_STATE_W-1:0] {
        ST_RESET      = 4'd0,   // PC reset pulse
        ST_READY      = 4'd1,
        ST_FETCH_ADDR = 4'd2,   // PC to memory address
        ST_FETCH_IR   = 4'd3,   // Memory to IR, bump PC
        ST_DECODE     = 4'd4,
        ST_EXECUTE    = 4'd5,   // LD and OTM second half
        ST_ALU_WB     = 4'd6,   // ALU result to register file
        ST_HALT       = 4'd7    // Exit only through reset
    } seq_state_e;

    // --------------------------------------------------
    // Datapath mux selects
    // --------------------------------------------------
    typedef enum logic [1:0] {
        PC_BRANCH = 2'd0,       // Branch adder
        PC_RETURN = 2'd1,       // Stack register
        PC_SRC1   = 2'd2        // Register file port 1
    } pc_src_e;

    typedef enum logic [1:0] {
        ADDR_PC    = 2'd0,
        ADDR_SRC2  = 2'd1,      // Indexed store
        ADDR_IMM_L = 2'd2,      // Zero-extended low byte
        ADDR_IMM_H = 2'd3       // Zero-extended high field
    } addr_src_e;

    typedef enum logic [1:0] {
        DATA_IMM  = 2'd0,
        DATA_MEM  = 2'd1,
        DATA_ALU  = 2'd2,
        DATA_SRC1 = 2'd3
    } data_src_e;

    typedef enum logic {
        OUT_MEM = 1'b0,
        OUT_REG = 1'b1
    } out_src_e;

    // Full datapath control word, all enables active high
    typedef struct packed {
        logic                   pc_rst;
        logic                   pc_inc;
        logic                   pc_ld;
        pc_src_e                pc_src;
        logic                   bra_direct;
        logic                   stk_ld;
        logic                   ir_ld;
        logic                   mem_en;
        logic                   mem_wr;
        addr_src_e              addr_src;
        logic                   reg_we;
        data_src_e              data_src;
        logic                   alu_ld;
        cpu_isa_pkg::alu_op_e   alu_op;
        logic                   flg_ld;
        logic                   flg_rst;
        logic                   out_ld;
        out_src_e               out_sel;
    } ctrl_word_t;

endpackage

`default_nettype wire

/* logic/seq_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "seq_ctrl_macros.svh"

module seq_ctrl_top (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic [`SEQ_DATA_W-1:0]  ir,
    input  wire cpu_isa_pkg::alu_flags_t alu_flags,
    output seq_ctrl_pkg::ctrl_word_t     ctrl,
    output logic [`SEQ_REG_W-1:0]        src1,
    output logic [`SEQ_REG_W-1:0]        src2,
    output logic [`SEQ_REG_W-1:0]        dest,
    output logic                         ready,
    output logic                         halt
);

    cpu_isa_pkg::decoded_t    decoded;  // Combinational from ir and flags
    seq_ctrl_pkg::seq_state_e state;

    // --------------------------------------------------
    // Decode, sequence, encode
    // --------------------------------------------------
    instr_decoder u_decoder (
        .ir        (ir),
        .alu_flags (alu_flags),
        .decoded   (decoded)
    );

    seq_fsm u_fsm (
        .clk     (clk),
        .rst_n   (rst_n),
        .decoded (decoded),
        .state   (state)        // Only registered stage
    );

    ctrl_encoder u_encoder (
        .state   (state),
        .decoded (decoded),
        .ctrl    (ctrl),
        .ready   (ready),
        .halt    (halt)
    );

    // Register file indices straight from the IR
    assign src1 = decoded.src1;
    assign src2 = decoded.src2;
    assign dest = decoded.dest;

endmodule

`default_nettype wire

/* logic/seq_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module seq_fsm (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire cpu_isa_pkg::decoded_t  decoded,
    output seq_ctrl_pkg::seq_state_e    state
);

    seq_ctrl_pkg::seq_state_e next_state;

    // --------------------------------------------------
    // State register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= seq_ctrl_pkg::ST_RESET;
        end else begin
            state <= next_state;
        end
    end

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------
    always_comb begin
        next_state = seq_ctrl_pkg::ST_RESET;     // Illegal codes restart
        case (state)
            seq_ctrl_pkg::ST_RESET:      next_state = seq_ctrl_pkg::ST_READY;
            seq_ctrl_pkg::ST_READY:      next_state = seq_ctrl_pkg::ST_FETCH_ADDR;
            seq_ctrl_pkg::ST_FETCH_ADDR: next_state = seq_ctrl_pkg::ST_FETCH_IR;
            seq_ctrl_pkg::ST_FETCH_IR:   next_state = seq_ctrl_pkg::ST_DECODE;
            seq_ctrl_pkg::ST_DECODE: begin
                // Three-cycle instructions by default
                next_state = seq_ctrl_pkg::ST_FETCH_ADDR;
                if (decoded.opcode == cpu_isa_pkg::OP_HLT) begin
                    next_state = seq_ctrl_pkg::ST_HALT;
                end else if (decoded.opcode == cpu_isa_pkg::OP_LD ||
                             decoded.opcode == cpu_isa_pkg::OP_OTM) begin
                    next_state = seq_ctrl_pkg::ST_EXECUTE;   // Memory read latency
                end else if (decoded.is_alu && !decoded.ignore_dest) begin
                    next_state = seq_ctrl_pkg::ST_ALU_WB;    // Result write-back
                end
            end
            seq_ctrl_pkg::ST_EXECUTE:    next_state = seq_ctrl_pkg::ST_FETCH_ADDR;
            seq_ctrl_pkg::ST_ALU_WB:     next_state = seq_ctrl_pkg::ST_FETCH_ADDR;
            seq_ctrl_pkg::ST_HALT:       next_state = seq_ctrl_pkg::ST_HALT;  // Until reset
            default:                     next_state = seq_ctrl_pkg::ST_RESET;
        endcase
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+logic
logic/cpu_isa_pkg.sv
logic/seq_ctrl_pkg.sv
logic/instr_decoder.sv
logic/seq_fsm.sv
logic/ctrl_encoder.sv
logic/seq_ctrl_top.sv
dv/seq_ctrl_properties.sv
dv/seq_ctrl_checker.sv
dv/tb_seq_ctrl.sv
